// File: framestore_cfg.svh
// Framestore manager configuration
// Widths of the ZBT interface, plane offsets in the framestore banks,
// macroblock layout and the picture coding type of B pictures

`ifndef FRAMESTORE_CFG_SVH
`define FRAMESTORE_CFG_SVH

// ==================================================
// ZBT word interface
// ==================================================
`define ZBT_ADDR_W 19
`define ZBT_DATA_W 32

// ==================================================
// Plane layout inside one framestore bank
// ==================================================
// Luma starts at word 0, chroma planes follow in the upper half
`define ZBT_CB_OFFSET 19'h40000
`define ZBT_CR_OFFSET 19'h60000

// Four luma, one Cb and one Cr block per macroblock
`define MB_BLOCKS 6

// Picture coding type as carried in the picture header
`define B_PICTURE_CODE 2'd3

`endif

// File: zbt_pkg.sv
// Memory-side types of the framestore manager
// Word, address and request formats seen on the two ZBT banks,
// the motion compensation read ports and the decoder write path

`include "framestore_cfg.svh"

package zbt_pkg;

	typedef logic [`ZBT_ADDR_W-1:0] zbt_addr_t;
	typedef logic [`ZBT_DATA_W-1:0] zbt_word_t;

	// Bank request, also the format of both bitstream clients
	typedef struct packed {
		zbt_addr_t address;
		zbt_word_t write_data;
		logic      write_en;
	} zbt_req_t;

	// Motion compensation framestore read port
	typedef struct packed {
		zbt_addr_t address;
		logic      busy;
	} fs_read_req_t;

	// Packed pixel word from the raster addresser
	typedef struct packed {
		zbt_addr_t address;
		zbt_word_t data;
		logic      strobe;
	} dec_write_t;

endpackage

// File: picture_pkg.sv
// Picture-side types of the framestore manager
// Picture coding type and the image dimension taken from the
// sequence header

`include "framestore_cfg.svh"

package picture_pkg;

	// ==================================================
	// Picture coding type
	// ==================================================
	typedef enum logic [1:0] {
		PIC_I = 2'd1,
		PIC_P = 2'd2,
		PIC_B = `B_PICTURE_CODE
	} picture_type_t;

	// ==================================================
	// Image geometry
	// ==================================================
	// Horizontal size in pixels, a multiple of 16
	typedef logic [11:0] image_dim_t;

endpackage

// File: mb_write_addresser.sv
// Macroblock write addresser
// Walks the decoded byte stream through the 8x8 blocks of each
// macroblock, tracks luma and chroma base pointers in raster order
// and packs four bytes into one ZBT word per write strobe

`timescale 1ns/100ps

`include "framestore_cfg.svh"

module mb_write_addresser (
	input  logic                      internal_ZBT_clock,
	input  logic                      resetn,
	input  logic                      address_reset,
	input  picture_pkg::image_dim_t   image_horizontal,
	input  picture_pkg::picture_type_t picture_type,
	input  logic                      yuv_write_en,
	input  logic [7:0]                yuv_write_data,
	output zbt_pkg::dec_write_t       dec_write
);

	logic [5:0]         sample_count;
	logic [2:0]         block_count;
	logic [7:0]         mb_column;
	zbt_pkg::zbt_addr_t luma_base;
	zbt_pkg::zbt_addr_t chroma_base;
	zbt_pkg::zbt_addr_t word_addr;
	logic [7:0]         byte_hh;
	logic [7:0]         byte_hl;
	logic [7:0]         byte_lh;

	// ==================================================
	// Geometry derived from the image width
	// ==================================================
	zbt_pkg::zbt_addr_t width_ext;
	zbt_pkg::zbt_addr_t row_step;
	zbt_pkg::zbt_addr_t luma_row_jump;
	zbt_pkg::zbt_addr_t chroma_row_jump;
	zbt_pkg::zbt_addr_t luma_base_next;
	zbt_pkg::zbt_addr_t chroma_base_next;
	zbt_pkg::zbt_addr_t block_start_addr;
	logic [7:0]         mb_column_limit;
	logic               word_end;
	logic               block_done;
	logic               last_block;
	logic               last_column;

	assign width_ext = zbt_pkg::zbt_addr_t'(image_horizontal);
	assign mb_column_limit = image_horizontal[11:4] - 8'd1;

	// Line stride of the plane the current block sits in
	assign row_step = (block_count < 3'd4) ? (width_ext >> 2) : (width_ext >> 3);

	// Skip to the next macroblock row, past the 16 luma / 8 chroma lines
	assign luma_row_jump = (width_ext << 2) - (width_ext >> 2) + zbt_pkg::zbt_addr_t'(4);
	assign chroma_row_jump = width_ext - (width_ext >> 3) + zbt_pkg::zbt_addr_t'(2);

	assign word_end = yuv_write_en && (sample_count[1:0] == 2'b11);
	assign block_done = (sample_count == 6'h3f);
	assign last_block = (block_count == 3'(`MB_BLOCKS - 1));
	assign last_column = (mb_column == mb_column_limit);

	assign luma_base_next = last_column ? luma_base + luma_row_jump
		: luma_base + zbt_pkg::zbt_addr_t'(4);
	assign chroma_base_next = last_column ? chroma_base + chroma_row_jump
		: chroma_base + zbt_pkg::zbt_addr_t'(2);

	// Start address of the block that follows the current one
	always_comb begin
		case (block_count)
			3'd0:    block_start_addr = luma_base + zbt_pkg::zbt_addr_t'(2);
			3'd1:    block_start_addr = luma_base + (width_ext << 1);
			3'd2:    block_start_addr = luma_base + (width_ext << 1) + zbt_pkg::zbt_addr_t'(2);
			3'd3:    block_start_addr = `ZBT_CB_OFFSET + chroma_base;
			default: block_start_addr = `ZBT_CR_OFFSET + chroma_base;
		endcase
	end

	// ==================================================
	// Raster counters and word address
	// ==================================================
	always_ff @(posedge internal_ZBT_clock or negedge resetn) begin
		if (!resetn) begin
			sample_count <= '0;
			block_count <= '0;
			mb_column <= '0;
			luma_base <= '0;
			chroma_base <= '0;
			word_addr <= '0;
		end else if (address_reset) begin
			sample_count <= '0;
			block_count <= '0;
			mb_column <= '0;
			luma_base <= '0;
			chroma_base <= '0;
			word_addr <= '0;
		end else if (yuv_write_en) begin
			sample_count <= sample_count + 6'd1;
			if (block_done) begin
				if (last_block) begin
					block_count <= '0;
					mb_column <= last_column ? 8'd0 : mb_column + 8'd1;
					luma_base <= luma_base_next;
					chroma_base <= chroma_base_next;
					word_addr <= luma_base_next;
				end else begin
					block_count <= block_count + 3'd1;
					word_addr <= block_start_addr;
				end
			end else if (word_end) begin
				// Eighth byte of a block row moves down one line
				word_addr <= sample_count[2] ? word_addr + row_step - zbt_pkg::zbt_addr_t'(1)
					: word_addr + zbt_pkg::zbt_addr_t'(1);
			end
		end
	end

	// First three bytes of each word wait here for the fourth
	always_ff @(posedge internal_ZBT_clock) begin
		if (yuv_write_en) begin
			case (sample_count[1:0])
				2'b00:   byte_hh <= yuv_write_data;
				2'b01:   byte_hl <= yuv_write_data;
				2'b10:   byte_lh <= yuv_write_data;
				default: byte_lh <= byte_lh;
			endcase
		end
	end

	assign dec_write.address = word_addr;
	assign dec_write.data = {byte_hh, byte_hl, byte_lh, yuv_write_data};
	assign dec_write.strobe = word_end && (picture_type != picture_pkg::PIC_B);

endmodule

// File: frame_bank_sequencer.sv
// Frame bank sequencer
// Flips the forward/backward prediction banks on every reference
// picture, releases audio sync after two of them and paces the
// display pointer from the frame advance input

`timescale 1ns/100ps

module frame_bank_sequencer (
	input  logic                       internal_ZBT_clock,
	input  logic                       resetn,
	input  logic                       picture_start,
	input  picture_pkg::picture_type_t picture_type,
	input  logic                       frame_advance,
	input  logic                       audio_sync_in,
	output logic                       prediction_select,
	output logic                       display_select,
	output logic                       display_advance,
	output logic                       audio_sync_out
);

	logic       picture_start_d;
	logic       frame_advance_d;
	logic       advance_phase;
	logic [1:0] ref_count;
	logic       ref_start;
	logic       advance_edge;

	assign ref_start = picture_start && !picture_start_d
		&& (picture_type != picture_pkg::PIC_B);
	assign advance_edge = frame_advance && !frame_advance_d;

	// Sync holds once two reference pictures have started
	assign audio_sync_out = (ref_count == 2'd2);

	// ==================================================
	// Prediction pointer and display pointer
	// ==================================================
	always_ff @(posedge internal_ZBT_clock or negedge resetn) begin
		if (!resetn) begin
			picture_start_d <= 1'b0;
			frame_advance_d <= 1'b0;
			prediction_select <= 1'b0;
			ref_count <= 2'd0;
			advance_phase <= 1'b1;
			display_select <= 1'b0;
			display_advance <= 1'b0;
		end else begin
			picture_start_d <= picture_start;
			frame_advance_d <= frame_advance;

			if (ref_start) begin
				prediction_select <= !prediction_select;
				if (ref_count != 2'd2)
					ref_count <= ref_count + 2'd1;
			end

			// Display moves on every other frame advance
			display_advance <= 1'b0;
			if (advance_edge) begin
				advance_phase <= !advance_phase;
				if (advance_phase && audio_sync_in) begin
					display_select <= !display_select;
					display_advance <= 1'b1;
				end
			end
		end
	end

endmodule

// File: bank_port_router.sv
// Bank port router
// Combinational arbitration of ZBT banks 0 and 1 between the
// bitstream clients, decoder writes and motion compensation reads,
// plus steering of read data back to each client

`timescale 1ns/100ps

module bank_port_router (
	input  zbt_pkg::dec_write_t   dec_write,
	input  logic                  prediction_select,
	input  zbt_pkg::zbt_req_t     video_stream,
	input  zbt_pkg::zbt_req_t     audio_stream,
	input  zbt_pkg::fs_read_req_t fs_fwd,
	input  zbt_pkg::fs_read_req_t fs_bwd,
	input  zbt_pkg::zbt_word_t    bank0_read_data,
	input  zbt_pkg::zbt_word_t    bank1_read_data,
	output zbt_pkg::zbt_req_t     bank0,
	output zbt_pkg::zbt_req_t     bank1,
	output logic                  video_stream_access,
	output logic                  audio_stream_access,
	output logic                  framestore_busy,
	output zbt_pkg::zbt_word_t    video_stream_read_data,
	output zbt_pkg::zbt_word_t    audio_stream_read_data,
	output zbt_pkg::zbt_word_t    fs_fwd_data,
	output zbt_pkg::zbt_word_t    fs_bwd_data
);

	zbt_pkg::fs_read_req_t bank0_reader;
	zbt_pkg::fs_read_req_t bank1_reader;

	// Bitstream first, then decoder write, then framestore read
	function automatic zbt_pkg::zbt_req_t route_bank(
		input logic                  stream_access,
		input zbt_pkg::zbt_req_t     stream,
		input logic                  dec_hit,
		input zbt_pkg::dec_write_t   dec,
		input zbt_pkg::fs_read_req_t reader
	);
		zbt_pkg::zbt_req_t req;
		if (stream_access)
			req = stream;
		else if (dec_hit)
			req = '{address: dec.address, write_data: dec.data, write_en: 1'b1};
		else
			req = '{address: reader.address, write_data: dec.data, write_en: 1'b0};
		return req;
	endfunction

	// Forward reads bank 0 while the pointer is clear
	assign bank0_reader = prediction_select ? fs_bwd : fs_fwd;
	assign bank1_reader = prediction_select ? fs_fwd : fs_bwd;

	assign framestore_busy = dec_write.strobe;
	assign video_stream_access = !(dec_write.strobe || bank0_reader.busy);
	assign audio_stream_access = !(dec_write.strobe || bank1_reader.busy);

	assign bank0 = route_bank(video_stream_access, video_stream,
		dec_write.strobe && prediction_select, dec_write, bank0_reader);
	assign bank1 = route_bank(audio_stream_access, audio_stream,
		dec_write.strobe && !prediction_select, dec_write, bank1_reader);

	assign video_stream_read_data = bank0_read_data;
	assign audio_stream_read_data = bank1_read_data;
	assign fs_fwd_data = prediction_select ? bank1_read_data : bank0_read_data;
	assign fs_bwd_data = prediction_select ? bank0_read_data : bank1_read_data;

endmodule

// File: framestore_manager.sv
// Framestore manager, decoder side
// Raster write addressing, prediction and display bank sequencing
// and arbitration of ZBT banks 0 and 1, all on the ZBT clock

`timescale 1ns/100ps

module framestore_manager (
	input  logic                       internal_ZBT_clock,
	input  logic                       resetn,
	input  logic                       address_reset,
	input  picture_pkg::image_dim_t    image_horizontal,
	input  picture_pkg::picture_type_t picture_type,
	input  logic                       yuv_write_en,
	input  logic [7:0]                 yuv_write_data,
	input  logic                       picture_start,
	input  logic                       frame_advance,
	input  logic                       audio_sync_in,
	output logic                       display_select,
	output logic                       display_advance,
	output logic                       audio_sync_out,
	input  zbt_pkg::zbt_req_t          video_stream,
	input  zbt_pkg::zbt_req_t          audio_stream,
	input  zbt_pkg::fs_read_req_t      fs_fwd,
	input  zbt_pkg::fs_read_req_t      fs_bwd,
	input  zbt_pkg::zbt_word_t         bank0_read_data,
	input  zbt_pkg::zbt_word_t         bank1_read_data,
	output zbt_pkg::zbt_req_t          bank0,
	output zbt_pkg::zbt_req_t          bank1,
	output logic                       video_stream_access,
	output logic                       audio_stream_access,
	output logic                       framestore_busy,
	output zbt_pkg::zbt_word_t         video_stream_read_data,
	output zbt_pkg::zbt_word_t         audio_stream_read_data,
	output zbt_pkg::zbt_word_t         fs_fwd_data,
	output zbt_pkg::zbt_word_t         fs_bwd_data
);

	zbt_pkg::dec_write_t dec_write;
	logic                prediction_select;

	mb_write_addresser mb_write_addresser_i (
		.internal_ZBT_clock (internal_ZBT_clock),
		.resetn             (resetn),
		.address_reset      (address_reset),
		.image_horizontal   (image_horizontal),
		.picture_type       (picture_type),
		.yuv_write_en       (yuv_write_en),
		.yuv_write_data     (yuv_write_data),
		.dec_write          (dec_write)
	);

	frame_bank_sequencer frame_bank_sequencer_i (
		.internal_ZBT_clock (internal_ZBT_clock),
		.resetn             (resetn),
		.picture_start      (picture_start),
		.picture_type       (picture_type),
		.frame_advance      (frame_advance),
		.audio_sync_in      (audio_sync_in),
		.prediction_select  (prediction_select),
		.display_select     (display_select),
		.display_advance    (display_advance),
		.audio_sync_out     (audio_sync_out)
	);

	bank_port_router bank_port_router_i (
		.dec_write              (dec_write),
		.prediction_select      (prediction_select),
		.video_stream           (video_stream),
		.audio_stream           (audio_stream),
		.fs_fwd                 (fs_fwd),
		.fs_bwd                 (fs_bwd),
		.bank0_read_data        (bank0_read_data),
		.bank1_read_data        (bank1_read_data),
		.bank0                  (bank0),
		.bank1                  (bank1),
		.video_stream_access    (video_stream_access),
		.audio_stream_access    (audio_stream_access),
		.framestore_busy        (framestore_busy),
		.video_stream_read_data (video_stream_read_data),
		.audio_stream_read_data (audio_stream_read_data),
		.fs_fwd_data            (fs_fwd_data),
		.fs_bwd_data            (fs_bwd_data)
	);

endmodule

// File: tb_framestore_manager.sv
// Testbench for the framestore manager
// Random byte streams, bitstream requests and framestore reads are
// driven on the falling clock edge and every output is compared each
// cycle with a behavioral model of the raster, routing and sequencing
// rules. The model keeps both banks as arrays of written words.

`timescale 1ns/100ps

`include "framestore_cfg.svh"

module tb_framestore_manager;

	localparam int IMAGE_WIDTH = 64;
	localparam int MB_BYTES = `MB_BLOCKS * 64;

	logic                       internal_ZBT_clock;
	logic                       resetn;
	logic                       address_reset;
	picture_pkg::image_dim_t    image_horizontal;
	picture_pkg::picture_type_t picture_type;
	logic                       yuv_write_en;
	logic [7:0]                 yuv_write_data;
	logic                       picture_start;
	logic                       frame_advance;
	logic                       audio_sync_in;
	logic                       display_select;
	logic                       display_advance;
	logic                       audio_sync_out;
	zbt_pkg::zbt_req_t          video_stream;
	zbt_pkg::zbt_req_t          audio_stream;
	zbt_pkg::fs_read_req_t      fs_fwd;
	zbt_pkg::fs_read_req_t      fs_bwd;
	zbt_pkg::zbt_word_t         bank0_read_data;
	zbt_pkg::zbt_word_t         bank1_read_data;
	zbt_pkg::zbt_req_t          bank0;
	zbt_pkg::zbt_req_t          bank1;
	logic                       video_stream_access;
	logic                       audio_stream_access;
	logic                       framestore_busy;
	zbt_pkg::zbt_word_t         video_stream_read_data;
	zbt_pkg::zbt_word_t         audio_stream_read_data;
	zbt_pkg::zbt_word_t         fs_fwd_data;
	zbt_pkg::zbt_word_t         fs_bwd_data;

	// Model copy of the DUT state after each rising edge
	logic               model_pred;
	logic               model_disp_sel;
	logic               model_disp_adv;
	logic               model_phase;
	logic               model_start_d;
	logic               model_adv_d;
	int                 model_refs;
	int                 model_byte_count;
	logic [7:0]         model_bytes[$];
	// Bank contents keyed by {bank, word address}
	zbt_pkg::zbt_word_t model_mem[logic [19:0]];
	zbt_pkg::zbt_word_t dut_mem[logic [19:0]];

	logic [31:0] rng_state;
	int          mismatch_count;
	int          timeout_count;

	framestore_manager framestore_manager_i (.*);

	initial begin
		internal_ZBT_clock = 1'b0;
		forever #20 internal_ZBT_clock = !internal_ZBT_clock;
	end

	// ==================================================
	// Random numbers and compare tasks
	// ==================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	task automatic check_req(input string name, input zbt_pkg::zbt_req_t got,
		input zbt_pkg::zbt_req_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("CHECK FAILED %s: got address %h data %h write_en %h, expected %h %h %h",
				name, got.address, got.write_data, got.write_en,
				exp.address, exp.write_data, exp.write_en);
		end
	endtask

	task automatic check_word(input string name, input zbt_pkg::zbt_word_t got,
		input zbt_pkg::zbt_word_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	// ==================================================
	// Reference model
	// ==================================================
	// Word address of byte n from its pixel position in the plane
	function automatic zbt_pkg::zbt_addr_t word_address(input int n, input int width);
		int mb;
		int blk;
		int s;
		int mb_row;
		int mb_col;
		int x;
		int y;
		mb = n / MB_BYTES;
		blk = (n % MB_BYTES) / 64;
		s = n % 64;
		mb_row = mb / (width / 16);
		mb_col = mb % (width / 16);
		if (blk < 4) begin
			x = mb_col * 16 + (blk % 2) * 8 + s % 8;
			y = mb_row * 16 + (blk / 2) * 8 + s / 8;
			return zbt_pkg::zbt_addr_t'((y * width + x) / 4);
		end
		x = mb_col * 8 + s % 8;
		y = mb_row * 8 + s / 8;
		if (blk == 4)
			return `ZBT_CB_OFFSET + zbt_pkg::zbt_addr_t'((y * (width / 2) + x) / 4);
		return `ZBT_CR_OFFSET + zbt_pkg::zbt_addr_t'((y * (width / 2) + x) / 4);
	endfunction

	task automatic check_bank(input logic bank_index, input string name,
		input zbt_pkg::zbt_req_t got, input logic access, input zbt_pkg::zbt_req_t stream,
		input logic dec_hit, input zbt_pkg::zbt_addr_t addr, input zbt_pkg::zbt_word_t data,
		input zbt_pkg::fs_read_req_t reader);
		zbt_pkg::zbt_req_t exp;
		if (access) begin
			exp = stream;
		end else if (dec_hit) begin
			exp.address = addr;
			exp.write_data = data;
			exp.write_en = 1'b1;
		end else begin
			// Write data means nothing on a framestore read
			exp.address = reader.address;
			exp.write_data = got.write_data;
			exp.write_en = 1'b0;
		end
		check_req(name, got, exp);
		if (exp.write_en)
			model_mem[{bank_index, exp.address}] = exp.write_data;
		if (got.write_en === 1'b1)
			dut_mem[{bank_index, got.address}] = got.write_data;
	endtask

	task automatic check_outputs();
		logic                  strobe;
		logic                  access0;
		logic                  access1;
		zbt_pkg::zbt_addr_t    addr;
		zbt_pkg::zbt_word_t    data;
		zbt_pkg::fs_read_req_t reader0;
		zbt_pkg::fs_read_req_t reader1;
		strobe = yuv_write_en && (model_byte_count % 4 == 3)
			&& (picture_type != picture_pkg::PIC_B);
		addr = '0;
		data = '0;
		if (strobe) begin
			addr = word_address(model_byte_count, IMAGE_WIDTH);
			data = {model_bytes[0], model_bytes[1], model_bytes[2], yuv_write_data};
		end
		reader0 = model_pred ? fs_bwd : fs_fwd;
		reader1 = model_pred ? fs_fwd : fs_bwd;
		access0 = !(strobe || reader0.busy);
		access1 = !(strobe || reader1.busy);

		check_bit("framestore_busy", framestore_busy, strobe);
		check_bit("video_stream_access", video_stream_access, access0);
		check_bit("audio_stream_access", audio_stream_access, access1);
		check_bank(1'b0, "bank0", bank0, access0, video_stream, strobe && model_pred,
			addr, data, reader0);
		check_bank(1'b1, "bank1", bank1, access1, audio_stream, strobe && !model_pred,
			addr, data, reader1);
		check_word("video_stream_read_data", video_stream_read_data, bank0_read_data);
		check_word("audio_stream_read_data", audio_stream_read_data, bank1_read_data);
		check_word("fs_fwd_data", fs_fwd_data, model_pred ? bank1_read_data : bank0_read_data);
		check_word("fs_bwd_data", fs_bwd_data, model_pred ? bank0_read_data : bank1_read_data);
		check_bit("display_select", display_select, model_disp_sel);
		check_bit("display_advance", display_advance, model_disp_adv);
		check_bit("audio_sync_out", audio_sync_out, model_refs == 2);
	endtask

	// State change at the rising edge from the inputs held this cycle
	task automatic update_model();
		logic start_edge;
		logic adv_edge;
		start_edge = picture_start && !model_start_d;
		adv_edge = frame_advance && !model_adv_d;
		model_start_d = picture_start;
		model_adv_d = frame_advance;
		model_disp_adv = 1'b0;
		if (start_edge && picture_type != picture_pkg::PIC_B) begin
			model_pred = !model_pred;
			if (model_refs < 2)
				model_refs++;
		end
		if (adv_edge) begin
			if (model_phase && audio_sync_in) begin
				model_disp_sel = !model_disp_sel;
				model_disp_adv = 1'b1;
			end
			model_phase = !model_phase;
		end
		if (address_reset) begin
			model_byte_count = 0;
			model_bytes.delete();
		end else if (yuv_write_en) begin
			model_byte_count++;
			model_bytes.push_back(yuv_write_data);
			if (model_bytes.size() == 4)
				model_bytes.delete();
		end
	endtask

	// ==================================================
	// Stimulus
	// ==================================================
	task automatic drive_side_inputs();
		logic [31:0] r;
		r = next_random();
		video_stream.address = r[18:0];
		video_stream.write_en = r[31];
		video_stream.write_data = next_random();
		r = next_random();
		audio_stream.address = r[18:0];
		audio_stream.write_en = r[31];
		audio_stream.write_data = next_random();
		r = next_random();
		fs_fwd.address = r[18:0];
		fs_fwd.busy = r[31];
		r = next_random();
		fs_bwd.address = r[18:0];
		fs_bwd.busy = r[31];
		bank0_read_data = next_random();
		bank1_read_data = next_random();
	endtask

	// Called on a falling edge and returns on the next one
	task automatic cycle();
		drive_side_inputs();
		#5;
		check_outputs();
		update_model();
		@(negedge internal_ZBT_clock);
	endtask

	task automatic run_picture(input picture_pkg::picture_type_t kind, input int macroblocks);
		int          n;
		logic [31:0] r;
		address_reset = 1'b1;
		picture_type = kind;
		cycle();
		address_reset = 1'b0;
		picture_start = 1'b1;
		cycle();
		picture_start = 1'b0;
		n = 0;
		while (n < macroblocks * MB_BYTES) begin
			r = next_random();
			yuv_write_en = (r[1:0] != 2'b00);
			yuv_write_data = r[15:8];
			if (yuv_write_en)
				n++;
			cycle();
		end
		yuv_write_en = 1'b0;
		cycle();
	endtask

	task automatic wait_for_sync();
		int t;
		t = 0;
		while (!audio_sync_out && t < 16) begin
			cycle();
			t++;
		end
		if (!audio_sync_out) begin
			timeout_count++;
			$display("Timed out waiting for audio_sync_out to rise");
		end
	endtask

	task automatic advance_frames(input logic sync, input int edges);
		int          e;
		int          g;
		logic [31:0] r;
		audio_sync_in = sync;
		for (e = 0; e < edges; e++) begin
			r = next_random();
			frame_advance = 1'b1;
			for (g = 0; g <= int'(r[0]); g++)
				cycle();
			frame_advance = 1'b0;
			for (g = 0; g <= int'(r[2:1]); g++)
				cycle();
		end
	endtask

	task automatic random_pictures(input int count);
		int          p;
		int          g;
		logic [31:0] r;
		for (p = 0; p < count; p++) begin
			r = next_random();
			case (r[1:0])
				2'd0:    picture_type = picture_pkg::PIC_I;
				2'd1:    picture_type = picture_pkg::PIC_P;
				default: picture_type = picture_pkg::PIC_B;
			endcase
			// Start held for one or two cycles, only its rising edge counts
			picture_start = 1'b1;
			for (g = 0; g <= int'(r[4]); g++)
				cycle();
			picture_start = 1'b0;
			for (g = 0; g <= int'(r[3:2]); g++)
				cycle();
		end
	endtask

	task automatic compare_memories();
		if (model_mem.num() != dut_mem.num()) begin
			mismatch_count++;
			$display("Written bank locations differ in number: DUT %0d, model %0d",
				dut_mem.num(), model_mem.num());
		end
		foreach (model_mem[key]) begin
			if (!dut_mem.exists(key)) begin
				mismatch_count++;
				$display("Bank %0d word %h was never written by the DUT", key[19], key[18:0]);
			end else begin
				check_word("bank memory", dut_mem[key], model_mem[key]);
			end
		end
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		int i;
		rng_state = 32'd84;
		mismatch_count = 0;
		timeout_count = 0;
		resetn = 1'b0;
		address_reset = 1'b0;
		image_horizontal = 12'd64;
		picture_type = picture_pkg::PIC_I;
		yuv_write_en = 1'b0;
		yuv_write_data = 8'h00;
		picture_start = 1'b0;
		frame_advance = 1'b0;
		audio_sync_in = 1'b0;
		video_stream = '0;
		audio_stream = '0;
		fs_fwd = '0;
		fs_bwd = '0;
		bank0_read_data = '0;
		bank1_read_data = '0;
		model_pred = 1'b0;
		model_disp_sel = 1'b0;
		model_disp_adv = 1'b0;
		model_phase = 1'b1;
		model_start_d = 1'b0;
		model_adv_d = 1'b0;
		model_refs = 0;
		model_byte_count = 0;

		for (i = 0; i < 4; i++)
			@(negedge internal_ZBT_clock);
		resetn = 1'b1;

		// Bitstream traffic alone and then six macroblocks across a row wrap
		for (i = 0; i < 40; i++)
			cycle();
		run_picture(picture_pkg::PIC_I, 6);
		run_picture(picture_pkg::PIC_B, 2);
		run_picture(picture_pkg::PIC_P, 1);
		wait_for_sync();

		advance_frames(1'b1, 8);
		advance_frames(1'b0, 6);
		random_pictures(16);
		for (i = 0; i < 100; i++)
			cycle();
		compare_memories();

		$display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+.
zbt_pkg.sv
picture_pkg.sv
mb_write_addresser.sv
frame_bank_sequencer.sv
bank_port_router.sv
framestore_manager.sv
tb_framestore_manager.sv

// File: Makefile
# Verilator build and run of the framestore manager testbench

VERILATOR ?= verilator
TOP       ?= tb_framestore_manager
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
